// ==== common/wcache_cfg.svh ====
/*
 * Weight cache build sizes
 * Port count, RAM address and data widths, cache depth
 */
`ifndef WCACHE_CFG_SVH
`define WCACHE_CFG_SVH

// ========================================
// Sizes
// ========================================

// PE ports served by the cache
`define WC_NUM_PORTS    4

// Weight RAM read channel
`define WC_ADDR_W       13
`define WC_DATA_W       8

// Fully associative entries, power of two
`define WC_CACHE_DEPTH  32

`endif

// ==== common/wcache_ctrl_pkg.sv ====
/*
 * Weight cache control types
 * Control state, operating mode, cache entry index
 */
`include "wcache_cfg.svh"

package wcache_ctrl_pkg;

    typedef enum logic [1:0] {
        st_idle,   // Waiting for configuration
        st_cfg,    // Mode being latched
        st_work    // Serving PE requests
    } ctrl_state_e;

    typedef enum logic {
        mode_bypass,   // Every request goes to RAM
        mode_cache     // Hits answered locally
    } cache_mode_e;

    typedef logic [$clog2(`WC_CACHE_DEPTH)-1:0] cache_idx_t;

endpackage

// ==== common/wcache_ifs.sv ====
/*
 * Internal weight cache interfaces
 * cache_lookup_if  per-port tag lookup and cache fill
 * grant_if         accepted requests and read completion
 */
`timescale 1ns/100ps
`include "wcache_cfg.svh"

// ========================================
// Lookup and fill
// ========================================
interface cache_lookup_if;
    wram_pkg::wram_addr_t [`WC_NUM_PORTS-1:0] lk_addr;    // Current port addresses
    wram_pkg::port_vec_t                      hit;
    wram_pkg::wram_data_t [`WC_NUM_PORTS-1:0] hit_data;
    logic                                     fill;       // RAM data accepted
    wram_pkg::wram_data_t                     fill_data;

    modport arbiter  (output lk_addr, input hit);
    modport cache    (input lk_addr, output hit, output hit_data,
                      input fill, input fill_data);
    modport returner (input hit_data, output fill, output fill_data);
endinterface

// ========================================
// Grant and completion
// ========================================
interface grant_if;
    logic                 grant_fire;   // RAM address accepted
    wram_pkg::wram_addr_t grant_addr;
    wram_pkg::port_vec_t  grant_ports;  // Merged port set
    wram_pkg::port_vec_t  grant_lst;
    wram_pkg::port_vec_t  hit_fire;     // Per-port hit accepted
    logic                 read_done;    // RAM data accepted

    modport arbiter  (output grant_fire, output grant_addr, output grant_ports,
                      output grant_lst, output hit_fire, input read_done);
    modport returner (input grant_fire, input grant_ports, input grant_lst,
                      input hit_fire, output read_done);
    modport cache    (input grant_fire, input grant_addr);
endinterface

// ==== common/wram_pkg.sv ====
/*
 * Weight RAM side types
 * Address, weight data and per-port bit vector
 */
`include "wcache_cfg.svh"

package wram_pkg;

    // One weight RAM word address
    typedef logic [`WC_ADDR_W-1:0] wram_addr_t;

    // One weight
    typedef logic [`WC_DATA_W-1:0] wram_data_t;

    // One bit per PE port
    typedef logic [`WC_NUM_PORTS-1:0] port_vec_t;

endpackage

// ==== filelist.f ====
+incdir+common
common/wram_pkg.sv
common/wcache_ctrl_pkg.sv
common/wcache_ifs.sv
weight_cache/wcache_ctrl.sv
weight_cache/port_arbiter.sv
weight_cache/hit_cache.sv
weight_cache/resp_return.sv
src/wcache_top.sv
sim/wcache_properties.sv
sim/tb_wcache.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the weight cache testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert --top-module tb_wcache -f filelist.f -o sim_wcache \
    && ./obj_dir/sim_wcache > sim.log 2>&1
cat sim.log 2>/dev/null
grep -qx "STATUS: PASS" sim.log && echo "Simulation passed" || { echo "Simulation failed"; exit 1; }

// ==== sim/tb_wcache.sv ====
/*
 * Weight cache testbench
 * Clock, reset, weight RAM model, random PE traffic,
 * per-port expected response queues and checks
 */
`timescale 1ns/100ps
`include "wcache_cfg.svh"

module tb_wcache;

    localparam int NP = `WC_NUM_PORTS;

    logic                                     clk = 1'b0;
    logic                                     rst_n = 1'b0;
    logic                                     cfg_vld = 1'b0;
    logic                                     cfg_cache_en = 1'b0;
    logic                                     cfg_rdy;
    wram_pkg::port_vec_t                      ptow_add_vld = '0;
    wram_pkg::port_vec_t                      ptow_add_lst = '0;
    wram_pkg::wram_addr_t [`WC_NUM_PORTS-1:0] ptow_add_addr = '0;
    wram_pkg::port_vec_t                      ptow_add_rdy;
    wram_pkg::port_vec_t                      ptow_dat_vld;
    wram_pkg::port_vec_t                      ptow_dat_lst;
    wram_pkg::wram_data_t [`WC_NUM_PORTS-1:0] ptow_dat_dat;
    wram_pkg::port_vec_t                      ptow_dat_rdy = '0;
    logic                                     wram_add_vld;
    wram_pkg::wram_addr_t                     wram_add_addr;
    logic                                     wram_add_rdy = 1'b0;
    logic                                     wram_dat_vld = 1'b0;
    wram_pkg::wram_data_t                     wram_dat_dat = '0;
    logic                                     wram_dat_rdy;

    // Weight RAM model and traffic state
    wram_pkg::wram_data_t ram_mem [1 << `WC_ADDR_W];
    logic                 ram_busy = 1'b0;
    wram_pkg::wram_addr_t ram_addr = '0;
    int                   ram_wait = 0;
    int                   read_cnt [1 << `WC_ADDR_W];
    int                   reads_total = 0;
    wram_pkg::wram_addr_t addr_list [NP][64];
    int                   req_total [NP];
    int                   sent_cnt [NP];
    wram_pkg::wram_data_t exp_dat [NP][$];
    logic                 exp_lst [NP][$];
    logic                 run_en = 1'b0;
    logic                 probe_en = 1'b0;
    logic                 clr_stats = 1'b0;
    wram_pkg::wram_addr_t addr_set [16];
    logic                 used [16];

    wcache_top dut (.*);

    initial begin
        forever #2 clk = ~clk;
    end

    // ========================================
    // Failure reporting and compare tasks
    // ========================================
    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("STATUS: FAIL");
        $fatal(1, "run stopped at first error");
    endtask

    task automatic check_data(input wram_pkg::wram_data_t got, input wram_pkg::wram_data_t exp,
                              input string what);
        if (got !== exp)
            abort_run($sformatf("[FAIL] %0d ns: %s got %02h expected %02h",
                                $time, what, got, exp));
    endtask

    task automatic check_count(input int got, input int exp, input string what);
        if (got != exp)
            abort_run($sformatf("[FAIL] %0d ns: %s got %0d expected %0d",
                                $time, what, got, exp));
    endtask

    // Weight rule: low address byte times 7 plus 3
    function automatic wram_pkg::wram_data_t rule_weight(input wram_pkg::wram_addr_t a);
        logic [7:0] lo;
        lo = a[7:0];
        return wram_pkg::wram_data_t'(lo * 8'd7 + 8'd3);
    endfunction

    // ========================================
    // Input driver, falling edge
    // ========================================
    always @(negedge clk) begin
        for (int p = 0; p < NP; p++) begin
            if (probe_en) begin
                ptow_add_vld[p]  <= 1'b1;
                ptow_add_addr[p] <= wram_pkg::wram_addr_t'(p);
                ptow_add_lst[p]  <= 1'b0;
            end else if (run_en && sent_cnt[p] < req_total[p]) begin
                ptow_add_vld[p]  <= 1'b1;
                ptow_add_addr[p] <= addr_list[p][sent_cnt[p]];
                ptow_add_lst[p]  <= (sent_cnt[p] == req_total[p] - 1);
            end else begin
                ptow_add_vld[p]  <= 1'b0;
            end
            ptow_dat_rdy[p] <= ($urandom % 4 != 0);   // Random PE stall
        end
        wram_add_rdy <= ($urandom % 3 != 0);
        wram_dat_vld <= ram_busy && ram_wait == 0;
        wram_dat_dat <= ram_mem[ram_addr];
    end

    // ========================================
    // Monitor, rising edge
    // ========================================
    always @(posedge clk) begin
        if (clr_stats) begin
            reads_total = 0;
            foreach (read_cnt[a])
                read_cnt[a] = 0;
            for (int p = 0; p < NP; p++)
                sent_cnt[p] = 0;
        end else if (rst_n) begin
            for (int p = 0; p < NP; p++) begin
                if (ptow_dat_vld[p] && ptow_dat_rdy[p]) begin
                    if (exp_dat[p].size() == 0)
                        abort_run($sformatf("Port %0d returned data it never asked for", p));
                    check_data(ptow_dat_dat[p], exp_dat[p].pop_front(),
                               $sformatf("port %0d data", p));
                    check_count(int'(ptow_dat_lst[p]), int'(exp_lst[p].pop_front()),
                                $sformatf("port %0d last flag", p));
                end
                if (ptow_add_vld[p] && ptow_add_rdy[p]) begin
                    exp_dat[p].push_back(rule_weight(ptow_add_addr[p]));
                    exp_lst[p].push_back(ptow_add_lst[p]);
                    sent_cnt[p]++;
                end
            end
            if (wram_dat_vld && wram_dat_rdy)
                ram_busy = 1'b0;
            else if (ram_busy && ram_wait > 0)
                ram_wait--;
            if (wram_add_vld && wram_add_rdy) begin
                ram_busy = 1'b1;
                ram_addr = wram_add_addr;
                ram_wait = int'($urandom % 4);     // 1 to 4 cycles
                reads_total++;
                read_cnt[wram_add_addr]++;
            end
        end
    end

    // ========================================
    // Sequencing tasks
    // ========================================
    task automatic wait_cfg_rdy();
        int cyc;
        for (cyc = 0; cyc < 100; cyc++) begin
            @(posedge clk);
            if (cfg_rdy)
                break;
        end
        if (cyc == 100)
            abort_run("Timeout waiting for cfg_rdy");
    endtask

    task automatic configure(input logic en);
        if (!cfg_rdy) begin
            @(negedge clk);
            cfg_vld = 1'b1;                          // Leave work mode
            @(negedge clk);
            cfg_vld = 1'b0;
        end
        @(negedge clk);
        cfg_vld      = 1'b1;
        cfg_cache_en = en;
        wait_cfg_rdy();
        @(negedge clk);
        cfg_vld = 1'b0;
        repeat (2) @(posedge clk);
    endtask

    task automatic run_traffic(input string what);
        int  cyc;
        logic done;
        @(negedge clk);
        clr_stats = 1'b1;
        @(negedge clk);
        clr_stats = 1'b0;
        run_en    = 1'b1;
        done      = 1'b0;
        // Finished once all requests are in and the DUT shows nothing more
        for (cyc = 0; cyc < 5000 && !done; cyc++) begin
            @(posedge clk);
            #1;
            done = !ram_busy && ptow_dat_vld == '0;
            for (int p = 0; p < NP; p++)
                done = done && sent_cnt[p] == req_total[p];
        end
        if (!done)
            abort_run($sformatf("Timeout waiting for %s traffic to finish", what));
        @(negedge clk);
        run_en = 1'b0;
        for (int p = 0; p < NP; p++)
            check_count(exp_dat[p].size(), 0, $sformatf("%s port %0d queue", what, p));
    endtask

    task automatic load_cached_run();
        for (int i = 0; i < 16; i++)
            used[i] = 1'b0;
        for (int p = 0; p < NP; p++) begin
            req_total[p] = 12;
            for (int k = 0; k < 12; k++) begin
                int pick;
                pick = int'($urandom % 16);
                used[pick] = 1'b1;
                addr_list[p][k] = addr_set[pick];
            end
        end
    endtask

    task automatic verify_single_reads(input string what);
        int distinct;
        distinct = 0;
        for (int i = 0; i < 16; i++) begin
            if (used[i]) begin
                distinct++;
                check_count(read_cnt[addr_set[i]], 1,
                            $sformatf("%s reads of %0h", what, addr_set[i]));
            end
        end
        check_count(reads_total, distinct, {what, " total reads"});
    endtask

    // ========================================
    // Main sequence
    // ========================================
    initial begin
        int base;
        void'($urandom(32'hbf82));
        for (int i = 0; i < (1 << `WC_ADDR_W); i++)
            ram_mem[i] = wram_pkg::wram_data_t'((i % 256) * 7 + 3);
        for (int p = 0; p < NP; p++)
            req_total[p] = 0;
        repeat (10) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        // Nothing accepted before configuration
        @(posedge clk);
        check_count(int'(cfg_rdy), 1, "cfg_rdy after reset");
        probe_en = 1'b1;
        repeat (8) begin
            @(posedge clk);
            check_count(int'(ptow_add_rdy), 0, "ptow_add_rdy before config");
        end
        @(negedge clk);
        probe_en = 1'b0;
        check_count(reads_total, 0, "reads before config");

        // Bypass, one port
        configure(1'b0);
        req_total[0] = 20;
        for (int k = 0; k < 20; k++)
            addr_list[0][k] = wram_pkg::wram_addr_t'($urandom);
        run_traffic("bypass");
        check_count(reads_total, 20, "bypass reads");

        // Cache mode, four ports over 16 addresses
        base = int'($urandom % 4096);
        for (int i = 0; i < 16; i++)
            addr_set[i] = wram_pkg::wram_addr_t'(base + i * 37);
        configure(1'b1);
        load_cached_run();
        run_traffic("cache");
        verify_single_reads("cache");

        // Same address on all ports, one merged read
        configure(1'b0);
        base = int'($urandom);
        for (int p = 0; p < NP; p++) begin
            req_total[p]    = 1;
            addr_list[p][0] = wram_pkg::wram_addr_t'(base);
        end
        run_traffic("merge");
        check_count(reads_total, 1, "merged reads");

        // Reconfigured cache starts empty
        configure(1'b1);
        load_cached_run();
        run_traffic("recache");
        verify_single_reads("recache");

        $display("STATUS: PASS");
        $finish;
    end

endmodule

// ==== sim/wcache_properties.sv ====
/*
 * Concurrent checks on the weight cache top level
 * RAM address hold, response hold, single read, cfg_rdy
 */
`timescale 1ns/100ps

module wcache_properties (
    input logic                         clk,
    input logic                         rst_n,
    input logic                         cfg_rdy,
    input wram_pkg::port_vec_t          ptow_add_rdy,
    input logic                         wram_add_vld,
    input logic                         wram_add_rdy,
    input wram_pkg::wram_addr_t         wram_add_addr,
    input logic                         wram_dat_vld,
    input logic                         wram_dat_rdy,
    input wram_pkg::port_vec_t          ptow_dat_vld,
    input wram_pkg::port_vec_t          ptow_dat_rdy
);

    logic rd_open;   // RAM read granted, data not yet taken

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            rd_open <= 1'b0;
        else if (wram_add_vld && wram_add_rdy)
            rd_open <= 1'b1;
        else if (wram_dat_vld && wram_dat_rdy)
            rd_open <= 1'b0;
    end

    a_add_hold: assert property (@(posedge clk) disable iff (!rst_n)
        wram_add_vld && !wram_add_rdy |=> wram_add_vld && $stable(wram_add_addr))
        else $error("wram_add_vld or address dropped before acceptance");

    a_dat_hold: assert property (@(posedge clk) disable iff (!rst_n)
        (ptow_dat_vld & ~ptow_dat_rdy) != '0 |=>
        (($past(ptow_dat_vld & ~ptow_dat_rdy) & ~ptow_dat_vld) == '0))
        else $error("ptow_dat_vld dropped before ready");

    a_one_read: assert property (@(posedge clk) disable iff (!rst_n)
        rd_open |-> !(wram_add_vld && wram_add_rdy))
        else $error("second RAM grant before read data returned");

    // Idle serves nothing, so cfg_rdy must not coexist with traffic
    a_cfg_idle: assert property (@(posedge clk) disable iff (!rst_n)
        cfg_rdy |-> !wram_add_vld && ptow_add_rdy == '0)
        else $error("cfg_rdy high while requests are served");

endmodule

bind wcache_top wcache_properties u_props (
    .clk           (clk),
    .rst_n         (rst_n),
    .cfg_rdy       (cfg_rdy),
    .ptow_add_rdy  (ptow_add_rdy),
    .wram_add_vld  (wram_add_vld),
    .wram_add_rdy  (wram_add_rdy),
    .wram_add_addr (wram_add_addr),
    .wram_dat_vld  (wram_dat_vld),
    .wram_dat_rdy  (wram_dat_rdy),
    .ptow_dat_vld  (ptow_dat_vld),
    .ptow_dat_rdy  (ptow_dat_rdy)
);

// ==== src/wcache_top.sv ====
/*
 * Weight cache top level
 * Control FSM, arbiter, cache and response return
 */
`timescale 1ns/100ps
`include "wcache_cfg.svh"

module wcache_top (
    input  logic                                     clk,
    input  logic                                     rst_n,
    // Configuration
    input  logic                                     cfg_vld,
    input  logic                                     cfg_cache_en,
    output logic                                     cfg_rdy,
    // PE requests
    input  wram_pkg::port_vec_t                      ptow_add_vld,
    input  wram_pkg::port_vec_t                      ptow_add_lst,
    input  wram_pkg::wram_addr_t [`WC_NUM_PORTS-1:0] ptow_add_addr,
    output wram_pkg::port_vec_t                      ptow_add_rdy,
    // PE responses
    output wram_pkg::port_vec_t                      ptow_dat_vld,
    output wram_pkg::port_vec_t                      ptow_dat_lst,
    output wram_pkg::wram_data_t [`WC_NUM_PORTS-1:0] ptow_dat_dat,
    input  wram_pkg::port_vec_t                      ptow_dat_rdy,
    // Weight RAM read
    output logic                                     wram_add_vld,
    output wram_pkg::wram_addr_t                     wram_add_addr,
    input  logic                                     wram_add_rdy,
    input  logic                                     wram_dat_vld,
    input  wram_pkg::wram_data_t                     wram_dat_dat,
    output logic                                     wram_dat_rdy
);

    wcache_ctrl_pkg::ctrl_state_e state;
    wcache_ctrl_pkg::cache_mode_e mode;
    wram_pkg::port_vec_t          slot_free;

    cache_lookup_if lk_if ();
    grant_if        gr_if ();

    wcache_ctrl u_ctrl (
        .clk          (clk),
        .rst_n        (rst_n),
        .cfg_vld      (cfg_vld),
        .cfg_cache_en (cfg_cache_en),
        .cfg_rdy      (cfg_rdy),
        .state        (state),
        .mode         (mode)
    );

    port_arbiter u_arb (
        .clk           (clk),
        .rst_n         (rst_n),
        .state         (state),
        .mode          (mode),
        .ptow_add_vld  (ptow_add_vld),
        .ptow_add_lst  (ptow_add_lst),
        .ptow_add_addr (ptow_add_addr),
        .ptow_add_rdy  (ptow_add_rdy),
        .wram_add_vld  (wram_add_vld),
        .wram_add_rdy  (wram_add_rdy),
        .wram_add_addr (wram_add_addr),
        .slot_free     (slot_free),
        .lookup        (lk_if.arbiter),
        .grant         (gr_if.arbiter)
    );

    hit_cache u_cache (
        .clk    (clk),
        .rst_n  (rst_n),
        .state  (state),
        .mode   (mode),
        .lookup (lk_if.cache),
        .grant  (gr_if.cache)
    );

    resp_return u_ret (
        .clk          (clk),
        .rst_n        (rst_n),
        .state        (state),
        .wram_dat_vld (wram_dat_vld),
        .wram_dat_dat (wram_dat_dat),
        .wram_dat_rdy (wram_dat_rdy),
        .ptow_dat_vld (ptow_dat_vld),
        .ptow_dat_lst (ptow_dat_lst),
        .ptow_dat_dat (ptow_dat_dat),
        .ptow_dat_rdy (ptow_dat_rdy),
        .slot_free    (slot_free),
        .lookup       (lk_if.returner),
        .grant        (gr_if.returner)
    );

endmodule

// ==== weight_cache/hit_cache.sv ====
/*
 * Fully associative weight cache
 * Tag and data arrays, per-port lookup, round-robin fill
 */
`timescale 1ns/100ps
`include "wcache_cfg.svh"

module hit_cache (
    input  logic                         clk,
    input  logic                         rst_n,
    input  wcache_ctrl_pkg::ctrl_state_e state,
    input  wcache_ctrl_pkg::cache_mode_e mode,
    cache_lookup_if.cache                lookup,
    grant_if.cache                       grant
);

    wram_pkg::wram_addr_t        tag_mem [`WC_CACHE_DEPTH];
    wram_pkg::wram_data_t        dat_mem [`WC_CACHE_DEPTH];
    logic [`WC_CACHE_DEPTH-1:0]  ent_vld;
    wcache_ctrl_pkg::cache_idx_t victim;
    wram_pkg::wram_addr_t        fill_addr;   // Address of the read in flight
    logic                        fill_en;

    assign fill_en = lookup.fill & (mode == wcache_ctrl_pkg::mode_cache);

    // ========================================
    // Lookup
    // ========================================
    always_comb begin
        lookup.hit      = '0;
        lookup.hit_data = '0;
        for (int p = 0; p < `WC_NUM_PORTS; p++) begin
            for (int e = 0; e < `WC_CACHE_DEPTH; e++) begin
                if (ent_vld[e] && tag_mem[e] == lookup.lk_addr[p]) begin
                    lookup.hit[p]      = 1'b1;
                    lookup.hit_data[p] = dat_mem[e];
                end
            end
        end
    end

    // ========================================
    // Fill
    // ========================================
    always_ff @(posedge clk) begin
        if (grant.grant_fire)
            fill_addr <= grant.grant_addr;
        if (fill_en) begin
            tag_mem[victim] <= fill_addr;
            dat_mem[victim] <= lookup.fill_data;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ent_vld <= '0;
            victim  <= '0;
        end else if (state == wcache_ctrl_pkg::st_idle) begin
            ent_vld <= '0;                        // Reconfigure empties the cache
            victim  <= '0;
        end else if (fill_en) begin
            ent_vld[victim] <= 1'b1;
            victim          <= victim + 1'b1;     // Oldest entry goes next
        end
    end

endmodule

// ==== weight_cache/port_arbiter.sv ====
/*
 * PE request arbiter
 * Hit acceptance, round-robin miss selection, address merge,
 * single outstanding RAM read
 */
`timescale 1ns/100ps
`include "wcache_cfg.svh"

module port_arbiter (
    input  logic                                     clk,
    input  logic                                     rst_n,
    input  wcache_ctrl_pkg::ctrl_state_e             state,
    input  wcache_ctrl_pkg::cache_mode_e             mode,
    input  wram_pkg::port_vec_t                      ptow_add_vld,
    input  wram_pkg::port_vec_t                      ptow_add_lst,
    input  wram_pkg::wram_addr_t [`WC_NUM_PORTS-1:0] ptow_add_addr,
    output wram_pkg::port_vec_t                      ptow_add_rdy,
    output logic                                     wram_add_vld,
    input  logic                                     wram_add_rdy,
    output wram_pkg::wram_addr_t                     wram_add_addr,
    input  wram_pkg::port_vec_t                      slot_free,
    cache_lookup_if.arbiter                          lookup,
    grant_if.arbiter                                 grant
);

    localparam int PIDX_W = $clog2(`WC_NUM_PORTS);

    logic                work;
    logic                cache_on;
    wram_pkg::port_vec_t hit_req;
    wram_pkg::port_vec_t miss_req;
    wram_pkg::port_vec_t cand;        // Misses with a free slot
    wram_pkg::port_vec_t merge;
    logic                found;
    logic [PIDX_W-1:0]   scan_idx;
    logic [PIDX_W-1:0]   sel_rr;
    logic [PIDX_W-1:0]   sel;
    logic [PIDX_W-1:0]   rr_ptr;
    logic                lock_q;      // Address offered, not yet taken
    logic [PIDX_W-1:0]   lock_sel;
    logic                outstanding;
    logic                grant_fire;

    assign work     = (state == wcache_ctrl_pkg::st_work);
    assign cache_on = (mode == wcache_ctrl_pkg::mode_cache);

    assign lookup.lk_addr = ptow_add_addr;

    assign hit_req  = {`WC_NUM_PORTS{work & cache_on}} & ptow_add_vld & lookup.hit;
    assign miss_req = {`WC_NUM_PORTS{work}} & ptow_add_vld
                    & ~({`WC_NUM_PORTS{cache_on}} & lookup.hit);
    assign cand     = miss_req & slot_free;

    // ========================================
    // Round-robin pick and merge
    // ========================================
    always_comb begin
        found  = 1'b0;
        sel_rr = rr_ptr;
        // Walk backwards so the nearest port to rr_ptr wins
        for (int i = `WC_NUM_PORTS - 1; i >= 0; i--) begin
            scan_idx = rr_ptr + PIDX_W'(i);
            if (cand[scan_idx]) begin
                found  = 1'b1;
                sel_rr = scan_idx;
            end
        end
    end

    assign sel = lock_q ? lock_sel : sel_rr;   // Keep address stable while offered

    always_comb begin
        for (int p = 0; p < `WC_NUM_PORTS; p++)
            merge[p] = cand[p] & (ptow_add_addr[p] == ptow_add_addr[sel]);
    end

    assign wram_add_vld  = work & (lock_q | found) & ~outstanding;
    assign wram_add_addr = ptow_add_addr[sel];
    assign grant_fire    = wram_add_vld & wram_add_rdy;

    // Hits go straight in, misses ride on the RAM address
    assign ptow_add_rdy = (hit_req & slot_free) | ({`WC_NUM_PORTS{grant_fire}} & merge);

    assign grant.grant_fire  = grant_fire;
    assign grant.grant_addr  = wram_add_addr;
    assign grant.grant_ports = merge;
    assign grant.grant_lst   = ptow_add_lst;
    assign grant.hit_fire    = hit_req & slot_free;

    // ========================================
    // Pointer, lock and outstanding read
    // ========================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rr_ptr      <= '0;
            lock_q      <= 1'b0;
            lock_sel    <= '0;
            outstanding <= 1'b0;
        end else if (!work) begin
            rr_ptr      <= '0;
            lock_q      <= 1'b0;
            lock_sel    <= '0;
            outstanding <= 1'b0;
        end else begin
            lock_q <= wram_add_vld & ~wram_add_rdy;
            if (wram_add_vld & ~wram_add_rdy)
                lock_sel <= sel;
            if (grant_fire) begin
                rr_ptr      <= sel + 1'b1;    // Next port gets priority
                outstanding <= 1'b1;
            end else if (grant.read_done) begin
                outstanding <= 1'b0;
            end
        end
    end

endmodule

// ==== weight_cache/resp_return.sv ====
/*
 * Per-port response return
 * Registered hit responses, RAM data fan-out to merged ports,
 * slot tracking and read completion
 */
`timescale 1ns/100ps
`include "wcache_cfg.svh"

module resp_return (
    input  logic                                     clk,
    input  logic                                     rst_n,
    input  wcache_ctrl_pkg::ctrl_state_e             state,
    input  logic                                     wram_dat_vld,
    input  wram_pkg::wram_data_t                     wram_dat_dat,
    output logic                                     wram_dat_rdy,
    output wram_pkg::port_vec_t                      ptow_dat_vld,
    output wram_pkg::port_vec_t                      ptow_dat_lst,
    output wram_pkg::wram_data_t [`WC_NUM_PORTS-1:0] ptow_dat_dat,
    input  wram_pkg::port_vec_t                      ptow_dat_rdy,
    output wram_pkg::port_vec_t                      slot_free,
    cache_lookup_if.returner                         lookup,
    grant_if.returner                                grant
);

    wram_pkg::port_vec_t                      hit_vld;
    wram_pkg::port_vec_t                      hit_lst;
    wram_pkg::wram_data_t [`WC_NUM_PORTS-1:0] hit_dat;
    wram_pkg::port_vec_t                      pend;       // Ports still owed RAM data
    wram_pkg::port_vec_t                      pend_lst;
    wram_pkg::port_vec_t                      ram_vld;
    wram_pkg::port_vec_t                      hit_drain;

    assign ram_vld   = {`WC_NUM_PORTS{wram_dat_vld}} & pend;
    assign hit_drain = hit_vld & ~ram_vld & ptow_dat_rdy;
    assign slot_free = ~pend & (~hit_vld | ptow_dat_rdy);

    // RAM word retires once every waiting port takes it
    assign wram_dat_rdy     = (|pend) & ((pend & ~ptow_dat_rdy) == '0);
    assign grant.read_done  = wram_dat_vld & wram_dat_rdy;
    assign lookup.fill      = grant.read_done;
    assign lookup.fill_data = wram_dat_dat;

    // ========================================
    // Output mux, RAM data first
    // ========================================
    assign ptow_dat_vld = ram_vld | hit_vld;

    always_comb begin
        for (int p = 0; p < `WC_NUM_PORTS; p++) begin
            if (ram_vld[p]) begin
                ptow_dat_dat[p] = wram_dat_dat;
                ptow_dat_lst[p] = pend_lst[p];
            end else begin
                ptow_dat_dat[p] = hit_dat[p];
                ptow_dat_lst[p] = hit_lst[p];
            end
        end
    end

    // ========================================
    // State
    // ========================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            hit_vld <= '0;
            pend    <= '0;
        end else if (state == wcache_ctrl_pkg::st_idle) begin
            hit_vld <= '0;
            pend    <= '0;
        end else begin
            hit_vld <= grant.hit_fire | (hit_vld & ~hit_drain);
            if (grant.grant_fire)
                pend <= grant.grant_ports;
            else
                pend <= pend & ~(ram_vld & ptow_dat_rdy);   // Served ports drop out
        end
    end

    always_ff @(posedge clk) begin
        for (int p = 0; p < `WC_NUM_PORTS; p++) begin
            if (grant.hit_fire[p]) begin
                hit_dat[p] <= lookup.hit_data[p];
                hit_lst[p] <= grant.grant_lst[p];
            end
        end
        if (grant.grant_fire)
            pend_lst <= grant.grant_lst;
    end

endmodule

// ==== weight_cache/wcache_ctrl.sv ====
/*
 * Configuration FSM of the weight cache
 * Sequences idle, configure and work, holds the mode
 */
`timescale 1ns/100ps

module wcache_ctrl (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         cfg_vld,
    input  logic                         cfg_cache_en,
    output logic                         cfg_rdy,
    output wcache_ctrl_pkg::ctrl_state_e state,
    output wcache_ctrl_pkg::cache_mode_e mode
);

    wcache_ctrl_pkg::ctrl_state_e state_nxt;

    always_comb begin
        state_nxt = state;
        case (state)
            wcache_ctrl_pkg::st_idle: begin
                if (cfg_vld)
                    state_nxt = wcache_ctrl_pkg::st_cfg;
            end
            wcache_ctrl_pkg::st_cfg:  state_nxt = wcache_ctrl_pkg::st_work;
            wcache_ctrl_pkg::st_work: begin
                if (cfg_vld)                                // Reconfigure request
                    state_nxt = wcache_ctrl_pkg::st_idle;
            end
            default:                  state_nxt = wcache_ctrl_pkg::st_idle;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            state <= wcache_ctrl_pkg::st_idle;
        else
            state <= state_nxt;
    end

    assign cfg_rdy = (state == wcache_ctrl_pkg::st_idle);

    // Mode taken on the way out of st_cfg
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            mode <= wcache_ctrl_pkg::mode_bypass;
        else if (state == wcache_ctrl_pkg::st_idle)
            mode <= wcache_ctrl_pkg::mode_bypass;
        else if (state == wcache_ctrl_pkg::st_cfg)
            mode <= cfg_cache_en ? wcache_ctrl_pkg::mode_cache : wcache_ctrl_pkg::mode_bypass;
    end

endmodule
